//--- files.f
+incdir+.
vdc_pkg.sv
vdc_regs.sv
vdc_beam.sv
vdc_palette.sv
vdc_top.sv
tb_vdc.sv

//--- Bender.yml
package:
  name: vdc

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - vdc_pkg.sv
      - vdc_regs.sv
      - vdc_beam.sv
      - vdc_palette.sv
      - vdc_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_vdc.sv

//--- tb_vdc.sv
`include "vdc_defines.svh"

module tb_vdc;

	localparam int          TIMEOUT_CYCLES = 20000;     // About 12 frames of 400 plus bus traffic and margin
	localparam logic [31:0] RAND_SEED      = 32'h69a7da1b;

	// Reference query kinds
	localparam int REF_READ  = 0;
	localparam int REF_RGB   = 1;
	localparam int REF_FRAME = 2;
	localparam int REF_HSYNC = 3;
	localparam int REF_VSYNC = 4;
	localparam int REF_IRQ   = 5;

	// Power-on colours with index 0 first
	localparam logic [0:15][23:0] DEFAULT_RGB = {
		24'h000000, 24'h555555, 24'h00007F, 24'h0000FF,
		24'h007F00, 24'h00FF00, 24'h007F7F, 24'h00FFFF,
		24'h7F0000, 24'hFF0000, 24'h3F003F, 24'hFF00FF,
		24'h3F3F00, 24'hFFFF00, 24'hAAAAAA, 24'hFFFFFF
	};

	// Kept registers plus a few unused numbers that read as ones
	localparam logic [0:13][6:0] REG_POOL = {
		7'd0, 7'd1, 7'd2, 7'd3, 7'd4, 7'd5, 7'd7,
		7'd9, 7'd22, 7'd37, 7'd43, 7'd44, 7'd45, 7'd46
	};

	logic          clk;
	logic          reset;
	logic          cs;
	logic          we;
	logic [7:0]    db_in;
	logic [6:0]    direct_reg;
	logic [3:0]    rgbi;
	logic [7:0]    db_out;
	logic          hsync;
	logic          vsync;
	logic          irq;
	vdc_pkg::rgb_t rgb;

	logic [7:0]  shadow_reg [128];     // Last value written per register number
	logic [23:0] shadow_pal [16];
	logic [5:0]  shadow_sel;           // Indirect select
	logic        ext_mode;

	logic [31:0] exp_q [$];            // Results waiting for the comparing process
	logic [31:0] act_q [$];
	string       msg_q [$];
	int          cycles;

	vdc_top i_dut (
		.clk        (clk),
		.reset      (reset),
		.cs         (cs),
		.we         (we),
		.db_in      (db_in),
		.direct_reg (direct_reg),
		.rgbi       (rgbi),
		.db_out     (db_out),
		.hsync      (hsync),
		.vsync      (vsync),
		.irq        (irq),
		.rgb        (rgb)
	);

	always #4 clk = ~clk;

	// --------------------
	// Reference model
	// --------------------
	function automatic logic [7:0] kept_mask(input int t);
		case (t)
			0, 2, 3, 4, 7:      kept_mask = 8'hFF;
			9:                  kept_mask = 8'h1F;   // ctv
			22:                 kept_mask = 8'hF0;   // cth in high nibble
			37:                 kept_mask = 8'hC0;   // Polarity bits
			38, 43, 44, 45, 46: kept_mask = ext_mode ? 8'hFF : 8'h00;
			default:            kept_mask = 8'h00;
		endcase
	endfunction

	function automatic int resolve_target(input logic [6:0] dreg);
		if (dreg == 7'd0) begin
			resolve_target = -1;                  // Select write or status read
		end else if (dreg == 7'd1 || !ext_mode) begin
			resolve_target = shadow_sel;
		end else begin
			resolve_target = dreg;
		end
	endfunction

	function automatic logic [31:0] vdc_ref(input int kind, input int arg);
		logic [7:0]  mask;
		logic [15:0] raster;
		logic [15:0] column;
		logic        hs;
		logic        vs;
		logic        hit_v;
		logic        hit_h;
		logic        irq_on;
		logic        hit;
		int          cnt;
		mask   = kept_mask(arg);
		raster = {shadow_reg[43], shadow_reg[44]};
		column = {shadow_reg[45], shadow_reg[46]};
		cnt    = 0;
		if (kind >= REF_FRAME) begin                // Walk one frame position by position
			for (int r = 0; r <= shadow_reg[4]; r++) begin
				for (int l = 0; l <= shadow_reg[9][4:0]; l++) begin
					for (int c = 0; c <= shadow_reg[0]; c++) begin
						for (int p = 0; p <= shadow_reg[22][7:4]; p++) begin
							hs = (c >= shadow_reg[2]) && (c < shadow_reg[2] + shadow_reg[3][3:0]);
							vs = (r == shadow_reg[7]) && (l < shadow_reg[3][7:4]);
							hit_v  = ext_mode && (r == raster[15:8]) && (l == raster[4:0]);
							hit_h  = ext_mode && (c == column[15:8]) && (p == column[3:0]);
							irq_on = (raster == `VDC_IRQ_OFF || column == `VDC_IRQ_OFF) ?
							         (hit_v || hit_h) : (hit_v && hit_h);
							case (kind)
								REF_HSYNC: hit = hs ^ shadow_reg[37][7];
								REF_VSYNC: hit = vs ^ shadow_reg[37][6];
								REF_IRQ:   hit = irq_on;
								default:   hit = 1'b1;      // Frame length
							endcase
							cnt += hit ? 1 : 0;
						end
					end
				end
			end
		end
		case (kind)
			REF_READ: vdc_ref = {24'd0, (shadow_reg[arg] & mask) | ~mask};
			REF_RGB:  vdc_ref = {8'd0, shadow_pal[arg]};
			default:  vdc_ref = cnt;
		endcase
	endfunction

	task automatic update_model(input logic [6:0] dreg, input logic [7:0] data);
		int t;
		int off;
		t = resolve_target(dreg);                   // Resolved with the mode before this write
		if (t < 0) begin
			shadow_sel = data[5:0];
		end else begin
			shadow_reg[t] = data;
			if (t == 38)
				ext_mode = (data == `VDC_TT8BG_KEY);
			if (t >= `VDC_RED_BASE && t < `VDC_BLUE_BASE + `VDC_PAL_SIZE) begin
				off = t - `VDC_RED_BASE;
				case (off / 16)
					0:       shadow_pal[off % 16][23:16] = data;
					1:       shadow_pal[off % 16][15:8]  = data;
					default: shadow_pal[off % 16][7:0]   = data;
				endcase
			end
		end
	endtask

	// --------------------
	// Checking
	// --------------------
	task automatic compare(input logic [31:0] act, input logic [31:0] exp, input string msg);
		if (act !== exp) begin
			$display("Mismatch at %0t: %s, got %0h, expected %0h", $time, msg, act, exp);
			$display("Done: errors found");
			$fatal(1, "Value check failed");
		end
	endtask

	// Results are queued on the falling edge and compared on the rising one
	always @(posedge clk) begin
		while (exp_q.size() > 0) begin
			compare(act_q.pop_front(), exp_q.pop_front(), msg_q.pop_front());
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Run timed out after %0d cycles", cycles);
			$display("Done: errors found");
			$fatal(1, "Timeout");
		end
	end

	task automatic queue_result(input logic [31:0] exp, input logic [31:0] act, input string msg);
		exp_q.push_back(exp);
		act_q.push_back(act);
		msg_q.push_back(msg);
	endtask

	// --------------------
	// Bus and pixel stimulus
	// --------------------
	task automatic write_reg(input logic [6:0] dreg, input logic [7:0] data);
		cs         = 1'b1;
		we         = 1'b1;
		direct_reg = dreg;
		db_in      = data;
		update_model(dreg, data);
		@(negedge clk);
		cs = 1'b0;
		we = 1'b0;
	endtask

	task automatic write_indirect(input logic [6:0] t, input logic [7:0] data);
		write_reg(7'd0, {1'b0, t});
		write_reg(7'd1, data);
	endtask

	task automatic expect_read(input logic [6:0] dreg, input string msg);
		logic [31:0] exp;
		int          t;
		t   = resolve_target(dreg);
		exp = (t < 0) ? 32'hFF : vdc_ref(REF_READ, t);
		cs         = 1'b1;
		we         = 1'b0;
		direct_reg = dreg;
		@(negedge clk);                             // db_out loaded at the edge in between
		cs = 1'b0;
		queue_result(exp, {24'd0, db_out}, msg);
	endtask

	task automatic expect_rgb(input int idx);
		rgbi = idx[3:0];
		@(negedge clk);
		queue_result(vdc_ref(REF_RGB, idx), {8'd0, rgb}, $sformatf("rgb of index %0d", idx));
	endtask

	task automatic wait_vsync_rise;
		logic prev;
		prev = vsync;
		@(negedge clk);
		while (!(vsync && !prev)) begin
			prev = vsync;
			@(negedge clk);
		end
	endtask

	task automatic check_frame(input string msg);
		logic prev;
		int   period;
		int   hs_cnt;
		int   vs_cnt;
		int   irq_cnt;
		period  = 0;
		hs_cnt  = 0;
		vs_cnt  = 0;
		irq_cnt = 0;
		wait_vsync_rise();                          // First edge may come from the config change
		wait_vsync_rise();
		do begin
			period++;
			hs_cnt  += hsync ? 1 : 0;
			vs_cnt  += vsync ? 1 : 0;
			irq_cnt += irq ? 1 : 0;
			prev = vsync;
			@(negedge clk);
		end while (!(vsync && !prev));
		queue_result(vdc_ref(REF_FRAME, 0), period, {msg, ", frame length"});
		queue_result(vdc_ref(REF_HSYNC, 0), hs_cnt, {msg, ", hsync cycles"});
		queue_result(vdc_ref(REF_VSYNC, 0), vs_cnt, {msg, ", vsync cycles"});
		queue_result(vdc_ref(REF_IRQ, 0), irq_cnt, {msg, ", irq cycles"});
	endtask

	// --------------------
	// Test sequence
	// --------------------
	initial begin
		logic [6:0]  t;
		logic [7:0]  d;
		clk        = 1'b0;
		reset      = 1'b1;
		cs         = 1'b0;
		we         = 1'b0;
		db_in      = '0;
		direct_reg = '0;
		rgbi       = '0;
		cycles     = 0;
		shadow_sel = '0;
		ext_mode   = 1'b0;
		for (int i = 0; i < 128; i++)
			shadow_reg[i] = (i >= 43 && i <= 46) ? 8'hFF : 8'h00;   // Interrupt positions unused
		for (int i = 0; i < 16; i++)
			shadow_pal[i] = DEFAULT_RGB[i];
		void'($urandom(RAND_SEED));
		repeat (10) @(negedge clk);
		reset = 1'b0;

		// Reset values through the indirect select
		for (int i = 0; i <= 36; i++) begin
			write_reg(7'd0, i[7:0]);
			expect_read(7'd1, $sformatf("reset value of R%0d", i));
		end
		write_reg(7'd0, 8'd38);
		expect_read(7'd1, "R38 outside extended mode");
		expect_read(7'd0, "status read");

		// Random indirect traffic where direct numbers still use the select
		for (int n = 0; n < 60; n++) begin
			t = REG_POOL[$urandom % 14];
			d = $urandom;
			write_indirect(t, d);
			t = REG_POOL[$urandom % 14];
			write_reg(7'd0, {1'b0, t});
			expect_read((n % 2 == 0) ? 7'd1 : 7'(2 + $urandom % 126),
			            $sformatf("read-back of R%0d", t));
		end

		// Locked palette and then random channel writes after the key
		for (int i = 0; i < 16; i++)
			expect_rgb(i);
		write_reg(7'd0, 8'd1);                      // Park the select on an unused register
		write_reg(7'd70, 8'h5A);
		expect_rgb(6);
		write_indirect(7'd38, `VDC_TT8BG_KEY);
		expect_read(7'd1, "R38 after the key");
		for (int n = 0; n < 40; n++) begin
			t = `VDC_RED_BASE + $urandom % 48;
			d = $urandom;
			write_reg(t, d);
			expect_rgb(t[3:0]);                     // Channel bases are multiples of 16
			expect_rgb($urandom % 16);
		end
		for (int i = 0; i < 16; i++)
			expect_rgb(i);

		// Small geometry of 400 cycles per frame
		write_indirect(7'd0, 8'd9);                 // ht
		write_indirect(7'd22, 8'h30);               // cth 3
		write_indirect(7'd9, 8'd1);                 // ctv
		write_indirect(7'd4, 8'd4);                 // vt
		write_indirect(7'd2, 8'd6);                 // hp
		write_indirect(7'd3, 8'h12);                // vw 1 and hw 2
		write_indirect(7'd7, 8'd3);                 // vp
		write_indirect(7'd37, 8'h00);
		for (int i = 43; i <= 46; i++)
			write_reg(i[6:0], 8'hFF);
		check_frame("normal polarity");
		write_indirect(7'd37, 8'hC0);
		check_frame("inverted polarity");

		// Interrupts in extended mode
		write_indirect(7'd37, 8'h00);
		write_reg(7'd43, 8'd2);                     // Raster row
		write_reg(7'd44, 8'd1);                     // Raster line
		check_frame("raster interrupt");
		write_reg(7'd45, 8'd5);                     // Column
		write_reg(7'd46, 8'd2);                     // Pixel
		check_frame("exact pixel interrupt");

		@(posedge clk);
		@(negedge clk);
		if (exp_q.size() == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			$display("Results left unchecked at the end of the run: %0d", exp_q.size());
			$display("Done: errors found");
			$fatal(1, "Unchecked results");
		end
	end

endmodule

//--- vdc_top.sv
module vdc_top (
	input  logic          clk,
	input  logic          reset,
	input  logic          cs,           // Chip select
	input  logic          we,           // Write enable
	input  logic [7:0]    db_in,
	input  logic [6:0]    direct_reg,   // 0 selects, 1 goes through the select, others are direct
	input  logic [3:0]    rgbi,         // From the pixel generator
	output logic [7:0]    db_out,
	output logic          hsync,
	output logic          vsync,
	output logic          irq,
	output vdc_pkg::rgb_t rgb
);

	vdc_pkg::beam_cfg_t cfg;
	vdc_pkg::beam_pos_t pos;
	vdc_pkg::pal_wr_t   pal_wr;

	vdc_regs i_regs (
		.clk        (clk),
		.reset      (reset),
		.cs         (cs),
		.we         (we),
		.db_in      (db_in),
		.direct_reg (direct_reg),
		.pos        (pos),
		.db_out     (db_out),
		.cfg        (cfg),
		.pal_wr     (pal_wr)
	);

	vdc_beam i_beam (
		.clk   (clk),
		.reset (reset),
		.cfg   (cfg),
		.pos   (pos),
		.hsync (hsync),
		.vsync (vsync),
		.irq   (irq)
	);

	vdc_palette i_palette (
		.clk    (clk),
		.reset  (reset),
		.pal_wr (pal_wr),
		.rgbi   (rgbi),
		.rgb    (rgb)
	);

endmodule

//--- vdc_palette.sv
`include "vdc_defines.svh"

module vdc_palette (
	input  logic                  clk,
	input  logic                  reset,
	input  vdc_pkg::pal_wr_t      pal_wr,
	input  logic [`VDC_IDX_W-1:0] rgbi,
	output vdc_pkg::rgb_t         rgb
);

	vdc_pkg::rgb_t pal [`VDC_PAL_SIZE];

	// Power-on RGBI colours
	function automatic vdc_pkg::rgb_t default_rgb(input int idx);
		case (idx)
			0:       default_rgb = 24'h000000;  // Black
			1:       default_rgb = 24'h555555;  // Dark grey
			2:       default_rgb = 24'h00007F;  // Dark blue
			3:       default_rgb = 24'h0000FF;  // Light blue
			4:       default_rgb = 24'h007F00;  // Dark green
			5:       default_rgb = 24'h00FF00;  // Light green
			6:       default_rgb = 24'h007F7F;  // Dark cyan
			7:       default_rgb = 24'h00FFFF;  // Light cyan
			8:       default_rgb = 24'h7F0000;  // Dark red
			9:       default_rgb = 24'hFF0000;  // Light red
			10:      default_rgb = 24'h3F003F;  // Dark magenta
			11:      default_rgb = 24'hFF00FF;  // Light magenta
			12:      default_rgb = 24'h3F3F00;  // Dark yellow
			13:      default_rgb = 24'hFFFF00;  // Light yellow
			14:      default_rgb = 24'hAAAAAA;  // Light grey
			default: default_rgb = 24'hFFFFFF;  // White
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `VDC_PAL_SIZE; i++) begin
				pal[i] <= default_rgb(i);
			end
		end else if (pal_wr.valid) begin
			case (pal_wr.chan)      // One channel of one entry per write
				vdc_pkg::CH_RED:   pal[pal_wr.index].red   <= pal_wr.value;
				vdc_pkg::CH_GREEN: pal[pal_wr.index].green <= pal_wr.value;
				vdc_pkg::CH_BLUE:  pal[pal_wr.index].blue  <= pal_wr.value;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		rgb <= pal[rgbi];   // One cycle behind rgbi
	end

endmodule

//--- vdc_beam.sv
`include "vdc_defines.svh"

module vdc_beam (
	input  logic               clk,
	input  logic               reset,
	input  vdc_pkg::beam_cfg_t cfg,
	output vdc_pkg::beam_pos_t pos,
	output logic               hsync,
	output logic               vsync,
	output logic               irq
);

	logic       pix_end;    // Last pixel of the cell
	logic       col_end;    // Last column of the scan line
	logic       line_end;   // Last line of the cell
	logic       row_end;    // Last row of the frame
	logic       step_line;
	logic       step_row;
	logic [8:0] hs_stop;    // First column past hsync
	logic       hs_raw;
	logic       vs_raw;
	logic       irq_v;
	logic       irq_h;
	logic       irq_any;    // One position unused, either hit fires

	// Compare with >= so a shrunk total wraps at once
	assign pix_end   = (pos.pixel >= cfg.cth);
	assign col_end   = (pos.col >= cfg.ht);
	assign line_end  = (pos.line >= cfg.ctv);
	assign row_end   = (pos.row >= cfg.vt);
	assign step_line = pix_end & col_end;
	assign step_row  = step_line & line_end;

	// --------------------
	// Beam counters
	// --------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			pos <= '0;
		end else begin
			pos.pixel <= pix_end ? 4'd0 : pos.pixel + 4'd1;
			if (pix_end) begin
				pos.col <= col_end ? 8'd0 : pos.col + 8'd1;
			end
			if (pos.line > cfg.ctv) begin
				pos.line <= '0;     // Resync after ctv was lowered mid cell
			end else if (step_line) begin
				pos.line <= line_end ? 5'd0 : pos.line + 5'd1;
			end
			if (step_row) begin
				pos.row <= row_end ? 8'd0 : pos.row + 8'd1;
			end
		end
	end

	// --------------------
	// Sync and interrupt
	// --------------------
	assign hs_stop = {1'b0, cfg.hp} + {5'd0, cfg.hw};
	assign hs_raw  = (pos.col >= cfg.hp) && ({1'b0, pos.col} < hs_stop);
	assign vs_raw  = (pos.row == cfg.vp) && (pos.line < {1'b0, cfg.vw});

	assign irq_v = cfg.tt8bg && (pos.row == cfg.irq_raster[15:8]) &&
	               (pos.line == cfg.irq_raster[4:0]);
	assign irq_h = cfg.tt8bg && (pos.col == cfg.irq_column[15:8]) &&
	               (pos.pixel == cfg.irq_column[3:0]);
	assign irq_any = (cfg.irq_raster == `VDC_IRQ_OFF) || (cfg.irq_column == `VDC_IRQ_OFF);

	always_ff @(posedge clk) begin
		if (reset) begin
			hsync <= 1'b0;
			vsync <= 1'b0;
			irq   <= 1'b0;
		end else begin
			hsync <= hs_raw ^ cfg.hspol;
			vsync <= vs_raw ^ cfg.vspol;
			irq   <= irq_any ? (irq_v | irq_h) : (irq_v & irq_h);   // Both set means an exact pixel
		end
	end

	// Counters stay in range except right after a register write
	a_pixel_range: assert property (@(posedge clk) disable iff (reset)
		!$changed(cfg) |-> pos.pixel <= cfg.cth);

	a_line_range: assert property (@(posedge clk) disable iff (reset)
		!$changed(cfg) |-> pos.line <= cfg.ctv);

endmodule

//--- vdc_regs.sv
`include "vdc_defines.svh"

module vdc_regs (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    cs,
	input  logic                    we,
	input  logic [`VDC_DATA_W-1:0]  db_in,
	input  logic [`VDC_REG_W-1:0]   direct_reg,
	input  vdc_pkg::beam_pos_t      pos,
	output logic [`VDC_DATA_W-1:0]  db_out,
	output vdc_pkg::beam_cfg_t      cfg,
	output vdc_pkg::pal_wr_t        pal_wr
);

	logic [`VDC_SEL_W-1:0]  sel;        // Indirect register select
	logic [`VDC_REG_W-1:0]  target;     // Register the cycle acts on
	logic [`VDC_REG_W-1:0]  pal_off;    // Offset from the channel base
	logic [`VDC_DATA_W-1:0] rd_val;
	logic                   wr_cyc;
	logic                   rd_cyc;
	logic                   sel_cyc;    // Direct register 0 addresses the select / status
	logic                   pal_hit;

	assign wr_cyc  = cs & we;
	assign rd_cyc  = cs & ~we;
	assign sel_cyc = (direct_reg == '0);

	// Direct numbers only reach the registers in extended mode, R1 keeps the indirect path
	assign target = (direct_reg == `VDC_REG_W'(1) || !cfg.tt8bg) ? {1'b0, sel} : direct_reg;

	// --------------------
	// Register writes
	// --------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			sel            <= '0;
			cfg            <= '0;               // Timing cleared, polarity normal, extended off
			cfg.irq_raster <= `VDC_IRQ_OFF;
			cfg.irq_column <= `VDC_IRQ_OFF;
		end else if (wr_cyc) begin
			if (sel_cyc) begin
				sel <= db_in[`VDC_SEL_W-1:0];
			end else begin
				case (target)
					vdc_pkg::REG_HT:       cfg.ht <= db_in;
					vdc_pkg::REG_HP:       cfg.hp <= db_in;
					vdc_pkg::REG_SYNCW: begin
						cfg.vw <= db_in[7:4];
						cfg.hw <= db_in[3:0];
					end
					vdc_pkg::REG_VT:       cfg.vt <= db_in;
					vdc_pkg::REG_VP:       cfg.vp <= db_in;
					vdc_pkg::REG_CTV:      cfg.ctv <= db_in[4:0];
					vdc_pkg::REG_CTH:      cfg.cth <= db_in[7:4];     // Low nibble not kept
					vdc_pkg::REG_POL: begin
						cfg.hspol <= db_in[7];
						cfg.vspol <= db_in[6];
					end
					vdc_pkg::REG_MODE:     cfg.tt8bg <= (db_in == `VDC_TT8BG_KEY);  // Any other value leaves extended mode
					vdc_pkg::REG_IRQ_ROW:  cfg.irq_raster[15:8] <= db_in;
					vdc_pkg::REG_IRQ_LINE: cfg.irq_raster[7:0]  <= db_in;
					vdc_pkg::REG_IRQ_COL:  cfg.irq_column[15:8] <= db_in;
					vdc_pkg::REG_IRQ_PIX:  cfg.irq_column[7:0]  <= db_in;
					default: ;                                        // Read-only or not kept
				endcase
			end
		end
	end

	// --------------------
	// Read-back
	// --------------------
	always_comb begin
		rd_val = `VDC_ALL_ONES;
		if (!sel_cyc) begin
			case (target)
				vdc_pkg::REG_HT:    rd_val = cfg.ht;
				vdc_pkg::REG_HP:    rd_val = cfg.hp;
				vdc_pkg::REG_SYNCW: rd_val = {cfg.vw, cfg.hw};
				vdc_pkg::REG_VT:    rd_val = cfg.vt;
				vdc_pkg::REG_VP:    rd_val = cfg.vp;
				vdc_pkg::REG_CTV:   rd_val = {3'b111, cfg.ctv};
				vdc_pkg::REG_CTH:   rd_val = {cfg.cth, 4'hF};
				vdc_pkg::REG_POL:   rd_val = {cfg.hspol, cfg.vspol, 6'h3F};
				default:            rd_val = `VDC_ALL_ONES;
			endcase
			// Extension registers are hidden until the key is written
			if (cfg.tt8bg) begin
				case (target)
					vdc_pkg::REG_MODE:     rd_val = `VDC_TT8BG_KEY;
					vdc_pkg::REG_COL:      rd_val = pos.col;
					vdc_pkg::REG_PIX:      rd_val = {4'hF, pos.pixel};
					vdc_pkg::REG_ROW:      rd_val = pos.row;
					vdc_pkg::REG_LINE:     rd_val = {3'b111, pos.line};
					vdc_pkg::REG_IRQ_ROW:  rd_val = cfg.irq_raster[15:8];
					vdc_pkg::REG_IRQ_LINE: rd_val = cfg.irq_raster[7:0];
					vdc_pkg::REG_IRQ_COL:  rd_val = cfg.irq_column[15:8];
					vdc_pkg::REG_IRQ_PIX:  rd_val = cfg.irq_column[7:0];
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_cyc) begin
			db_out <= rd_val;   // Held until the next read
		end
	end

	// --------------------
	// Palette requests
	// --------------------
	assign pal_hit = wr_cyc && !sel_cyc && target >= `VDC_RED_BASE &&
	                 target < (`VDC_BLUE_BASE + `VDC_REG_W'(`VDC_PAL_SIZE));

	always_comb begin
		pal_wr  = '0;
		pal_off = target - `VDC_RED_BASE;
		if (target >= `VDC_BLUE_BASE) begin
			pal_wr.chan = vdc_pkg::CH_BLUE;
			pal_off     = target - `VDC_BLUE_BASE;
		end else if (target >= `VDC_GREEN_BASE) begin
			pal_wr.chan = vdc_pkg::CH_GREEN;
			pal_off     = target - `VDC_GREEN_BASE;
		end else begin
			pal_wr.chan = vdc_pkg::CH_RED;
		end
		pal_wr.valid = pal_hit;
		pal_wr.index = pal_off[`VDC_IDX_W-1:0];
		pal_wr.value = db_in;
	end

	// Numbers above 63 only come from direct_reg, which extended mode gates
	a_pal_wr_ext: assert property (@(posedge clk) disable iff (reset)
		pal_wr.valid |-> cfg.tt8bg);

endmodule

//--- vdc_pkg.sv
package vdc_pkg;

	// Register numbers decoded by the register file
	typedef enum logic [6:0] {
		REG_HT        = 7'd0,   // Horizontal total
		REG_HP        = 7'd2,   // Horizontal sync position
		REG_SYNCW     = 7'd3,   // Vertical / horizontal sync width
		REG_VT        = 7'd4,   // Vertical total
		REG_VP        = 7'd7,   // Vertical sync position
		REG_CTV       = 7'd9,   // Character total vertical
		REG_CTH       = 7'd22,  // Character total horizontal in high nibble
		REG_POL       = 7'd37,  // Sync polarity
		REG_MODE      = 7'd38,  // Extended mode key
		REG_COL       = 7'd39,  // Current column, read only
		REG_PIX       = 7'd40,  // Current pixel in cell, read only
		REG_ROW       = 7'd41,  // Current row, read only
		REG_LINE      = 7'd42,  // Current line in cell, read only
		REG_IRQ_ROW   = 7'd43,  // Raster interrupt row
		REG_IRQ_LINE  = 7'd44,  // Raster interrupt line
		REG_IRQ_COL   = 7'd45,  // Column interrupt column
		REG_IRQ_PIX   = 7'd46   // Column interrupt pixel
	} vdc_reg_e;

	typedef enum logic [1:0] {
		CH_RED,
		CH_GREEN,
		CH_BLUE
	} pal_chan_e;

	// Timing and mode settings, register file to beam counters
	typedef struct packed {
		logic [7:0]  ht;          // Columns per scan line minus 1
		logic [7:0]  hp;          // Column where hsync starts
		logic [7:0]  vt;          // Rows per frame minus 1
		logic [7:0]  vp;          // Row that carries vsync
		logic [3:0]  hw;          // Hsync width in columns
		logic [3:0]  vw;          // Vsync width in lines
		logic [3:0]  cth;         // Pixels per cell minus 1
		logic [4:0]  ctv;         // Lines per cell minus 1
		logic        hspol;
		logic        vspol;
		logic        tt8bg;       // Extended mode
		logic [15:0] irq_raster;  // Row in high byte, line in low byte
		logic [15:0] irq_column;  // Column in high byte, pixel in low byte
	} beam_cfg_t;

	typedef struct packed {
		logic [7:0] col;
		logic [3:0] pixel;
		logic [7:0] row;
		logic [4:0] line;
	} beam_pos_t;

	typedef struct packed {
		logic       valid;
		pal_chan_e  chan;
		logic [3:0] index;
		logic [7:0] value;
	} pal_wr_t;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

endpackage

//--- vdc_defines.svh
`ifndef VDC_DEFINES_SVH
`define VDC_DEFINES_SVH

// --------------------
// Bus widths
// --------------------
`define VDC_DATA_W      8       // CPU data bus
`define VDC_REG_W       7       // Direct register number
`define VDC_SEL_W       6       // Indirect register select, written through R0 of the bus

// --------------------
// Palette
// --------------------
`define VDC_PAL_SIZE    16      // Entries per channel
`define VDC_IDX_W       4       // RGBI colour index
`define VDC_RED_BASE    7'd64   // R64..R79
`define VDC_GREEN_BASE  7'd80   // R80..R95
`define VDC_BLUE_BASE   7'd96   // R96..R111

// --------------------
// Magic values
// --------------------
`define VDC_TT8BG_KEY   8'h74   // R38 value that switches extended mode on
`define VDC_IRQ_OFF     16'hFFFF // Interrupt position not in use
`define VDC_ALL_ONES    8'hFF   // Status, undecoded and hidden reads

`endif
